// File: radar_capture.f
common/radar_cfg_pkg.sv
common/radar_types_pkg.sv
hdl/capture/capture_ctrl.sv
hdl/capture/frame_assembler.sv
hdl/frame_fifo.sv
hdl/radar_capture_top.sv
testbench/capture_checker.sv
testbench/tb_radar_capture.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the radar capture testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module tb_radar_capture \
  -f radar_capture.f \
  -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "^=== PASS ===$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// File: testbench/tb_radar_capture.sv
// radar capture framer testbench
// random I/Q samples and back-pressure from an LCG, six capture windows
// over both sources and route settings, checking done in capture_checker
module tb_radar_capture
  import radar_cfg_pkg::*;
  import radar_types_pkg::*;
();

  localparam int period_c     = 40;
  localparam int num_frames_c = 6;
  localparam int max_en_c     = 200;  // longest enable in cycles
  // enable, padding and both delays
  localparam int window_c   = max_en_c + 2 * frame_align_c + wfrm_start_dly_c + 8;
  localparam int watchdog_c = num_frames_c * window_c * 4 * period_c;

  logic          clk_245_76MHz;
  logic          cpu_reset;
  iq_sample_t    sample;
  capture_ctrl_t ctrl;
  frame_beat_t   m_beat;
  logic          m_valid, m_ready, overflow;
  logic          cnt_route;      // route mode of the frame in flight
  logic [31:0]   lcg_state;
  int            frames_done, beats_seen, error_cnt;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] dac_of(input logic [31:0] adc);
    logic [31:0] inv;
    inv = ~adc;
    return {inv[23:0], inv[31:24]};  // inverted, rotated left by 8
  endfunction

  function automatic logic [31:0] ctrl_word_of(input logic [1:0] src, input route_e hi,
                                               input route_e lo);
    return {22'd0, src, 2'b00, hi, 2'b00, lo};
  endfunction

  radar_capture_top #(.fifo_depth(256)) i_radar_capture_top (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .sample_i      (sample),
    .ctrl_i        (ctrl),
    .m_beat_o      (m_beat),
    .m_valid_o     (m_valid),
    .m_ready_i     (m_ready),
    .overflow_o    (overflow)
  );

  capture_checker i_capture_checker (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .m_beat_i      (m_beat),
    .m_valid_i     (m_valid),
    .m_ready_i     (m_ready),
    .overflow_i    (overflow),
    .cnt_route_i   (cnt_route),
    .frames_o      (frames_done),
    .beats_o       (beats_seen),
    .errors_o      (error_cnt)
  );

  initial begin
    clk_245_76MHz = 1'b0;
    forever #(period_c / 2) clk_245_76MHz = ~clk_245_76MHz;
  end

  // free running samples and ready, 2 units after each edge
  initial begin
    lcg_state = 32'hce40_b54d;
    sample    = '0;
    m_ready   = 1'b0;
    forever begin
      @(posedge clk_245_76MHz);
      #2;
      lcg_state     = lcg_next(lcg_state);
      sample.adc_iq = lcg_state;
      sample.dac_iq = dac_of(lcg_state);
      lcg_state     = lcg_next(lcg_state);
      sample.valid  = (lcg_state[31:30] != 2'b00);  // about 3 in 4
      m_ready       = lcg_state[29];
    end
  end

  // one capture window, waits until its trailer left the stream
  task automatic capture_frame(input logic [31:0] word, input int en_len, input logic mode,
                               input int frame_no);
    @(posedge clk_245_76MHz);
    #2;
    cnt_route      = mode;
    ctrl.ctrl_word = word;
    repeat (4) @(posedge clk_245_76MHz);  // selects latched
    #2;
    ctrl.chirp_enable = 1'b1;
    ctrl.adc_enable   = 1'b1;
    repeat (en_len) @(posedge clk_245_76MHz);
    #2;
    ctrl.adc_enable = 1'b0;
    wait (frames_done == frame_no);
    @(posedge clk_245_76MHz);
    #2;
    ctrl.chirp_enable = 1'b0;
  endtask

  initial begin
    cpu_reset = 1'b1;
    ctrl      = '0;
    cnt_route = 1'b0;
    repeat (8) @(posedge clk_245_76MHz);
    #2;
    cpu_reset = 1'b0;
    capture_frame(ctrl_word_of(2'b00, route_adc, route_dac), 80, 1'b0, 1);
    capture_frame(ctrl_word_of(2'b00, route_glbl_cnt, route_sample_cnt), 100, 1'b1, 2);
    capture_frame(ctrl_word_of(2'b11, route_adc, route_dac), 120, 1'b0, 3);  // waveform
    capture_frame(ctrl_word_of(2'b00, route_adc, route_dac), 60, 1'b0, 4);
    capture_frame(ctrl_word_of(2'b11, route_glbl_cnt, route_sample_cnt), 150, 1'b1, 5);
    capture_frame(ctrl_word_of(2'b00, route_adc, route_dac), max_en_c, 1'b0, 6);
    repeat (20) @(posedge clk_245_76MHz);
    $display("summary: frames %0d of %0d, beats %0d, errors %0d",
             frames_done, num_frames_c, beats_seen, error_cnt);
    if (error_cnt == 0 && frames_done == num_frames_c) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(watchdog_c);
    $display("timeout: frames not complete after %0d time units, %0d of %0d seen",
             watchdog_c, frames_done, num_frames_c);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// File: testbench/capture_checker.sv
// capture framer output checker
// follows the output stream beat by beat, rebuilds frame boundaries
// and checks markers, alignment, timestamps and data against reference rules
module capture_checker
  import radar_cfg_pkg::*;
  import radar_types_pkg::*;
(
  input  logic        clk_245_76MHz,
  input  logic        cpu_reset,
  input  frame_beat_t m_beat_i,
  input  logic        m_valid_i,
  input  logic        m_ready_i,
  input  logic        overflow_i,
  input  logic        cnt_route_i,  // 1: glbl cnt high, sample cnt low
  output int          frames_o,     // trailers seen
  output int          beats_o,      // beats taken off the stream
  output int          errors_o
);

  logic        in_frame;
  logic        have_hdr;       // a header seen before
  logic        have_lower;     // previous data beat in this frame
  logic        ovf_seen;
  logic [31:0] hdr_ts, prev_hdr_ts;
  logic [31:0] prev_lower, prev_upper;
  int          frame_len;

  // reference: dac word is the inverted adc word, rotated left by 8
  function automatic logic [31:0] dac_of(input logic [31:0] adc);
    logic [31:0] inv;
    inv = ~adc;
    return {inv[23:0], inv[31:24]};
  endfunction

  task automatic report_mismatch(input string msg);
    $display("Mismatch at time %0t: %s", $time, msg);
    errors_o++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stream monitor, sampled on the transfer edge
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      in_frame   = 1'b0;
      have_hdr   = 1'b0;
      have_lower = 1'b0;
      ovf_seen   = 1'b0;
      frame_len  = 0;
      frames_o   = 0;
      beats_o    = 0;
      errors_o   = 0;
    end else begin
      if (overflow_i && !ovf_seen) begin  // reported once, flag is sticky
        $display("Error at time %0t: FIFO overflow flagged, a beat was dropped", $time);
        errors_o++;
        ovf_seen = 1'b1;
      end
      if (m_valid_i && m_ready_i) begin
        beats_o++;
        if (!in_frame) begin  // first beat must be the FRST marker
          if (m_beat_i.word.marker.command != cmd_first_c || m_beat_i.last)
            report_mismatch($sformatf("frame %0d opens with %h, not FRST",
                                      frames_o, m_beat_i.word));
          hdr_ts = m_beat_i.word.marker.timestamp;
          if (have_hdr && hdr_ts <= prev_hdr_ts)
            report_mismatch($sformatf("header ts %0d not above previous %0d",
                                      hdr_ts, prev_hdr_ts));
          prev_hdr_ts = hdr_ts;
          have_hdr    = 1'b1;
          in_frame    = 1'b1;
          have_lower  = 1'b0;
          frame_len   = 1;
        end else begin
          frame_len++;
          if (m_beat_i.last) begin  // only the trailer carries last
            if (m_beat_i.word.marker.command != cmd_last_c)
              report_mismatch($sformatf("last beat command %h, not LAST",
                                        m_beat_i.word.marker.command));
            if (m_beat_i.word.marker.timestamp <= hdr_ts)
              report_mismatch($sformatf("trailer ts %0d not above header ts %0d",
                                        m_beat_i.word.marker.timestamp, hdr_ts));
            if (frame_len % frame_align_c != 0)
              report_mismatch($sformatf("frame %0d is %0d beats, not a multiple of %0d",
                                        frames_o, frame_len, frame_align_c));
            in_frame = 1'b0;
            frames_o++;
          end else if (!cnt_route_i) begin  // adc high, dac low
            if (m_beat_i.word.data.lower != dac_of(m_beat_i.word.data.upper))
              report_mismatch($sformatf("lower %h, expected %h from upper %h",
                                        m_beat_i.word.data.lower,
                                        dac_of(m_beat_i.word.data.upper),
                                        m_beat_i.word.data.upper));
          end else begin  // counters, sample count steps by one
            if (have_lower && m_beat_i.word.data.lower != prev_lower + 32'd1)
              report_mismatch($sformatf("sample count %0d after %0d",
                                        m_beat_i.word.data.lower, prev_lower));
            if (have_lower && m_beat_i.word.data.upper <= prev_upper)
              report_mismatch($sformatf("global count %0d after %0d",
                                        m_beat_i.word.data.upper, prev_upper));
            prev_lower = m_beat_i.word.data.lower;
            prev_upper = m_beat_i.word.data.upper;
            have_lower = 1'b1;
          end
        end
      end
    end
  end

endmodule

// File: hdl/radar_capture_top.sv
// radar capture framer
// capture window control, frame word assembly and the output FIFO;
// I/Q samples in, FRST..LAST framed beats out on a valid/ready stream
module radar_capture_top
  import radar_cfg_pkg::*;
  import radar_types_pkg::*;
#(
  parameter int fifo_depth = 256
) (
  input  logic          clk_245_76MHz,
  input  logic          cpu_reset,
  input  iq_sample_t    sample_i,
  input  capture_ctrl_t ctrl_i,
  output frame_beat_t   m_beat_o,
  output logic          m_valid_o,
  input  logic          m_ready_i,
  output logic          overflow_o
);

  slot_e       slot;          // slot of the registered sample
  route_e      route_hi;
  route_e      route_lo;
  iq_sample_t  ctrl_sample;
  frame_beat_t beat;          // fifo write side
  logic        beat_valid;

  capture_ctrl i_capture_ctrl (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .sample_i      (sample_i),
    .ctrl_i        (ctrl_i),
    .slot_o        (slot),
    .route_hi_o    (route_hi),
    .route_lo_o    (route_lo),
    .sample_o      (ctrl_sample)
  );

  frame_assembler i_frame_assembler (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .slot_i        (slot),
    .route_hi_i    (route_hi),
    .route_lo_i    (route_lo),
    .sample_i      (ctrl_sample),
    .beat_o        (beat),
    .beat_valid_o  (beat_valid)
  );

  frame_fifo #(
    .fifo_depth (fifo_depth)
  ) i_frame_fifo (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .beat_i        (beat),
    .beat_valid_i  (beat_valid),
    .m_beat_o      (m_beat_o),
    .m_valid_o     (m_valid_o),
    .m_ready_i     (m_ready_i),
    .overflow_o    (overflow_o)
  );

endmodule

// File: hdl/frame_fifo.sv
// single clock frame FIFO
// buffers assembled beats and presents the head as a valid/ready
// stream with last; writes into a full buffer are dropped and flagged
module frame_fifo
  import radar_types_pkg::*;
#(
  parameter int fifo_depth = 256
) (
  input  logic        clk_245_76MHz,
  input  logic        cpu_reset,
  input  frame_beat_t beat_i,
  input  logic        beat_valid_i,
  output frame_beat_t m_beat_o,
  output logic        m_valid_o,
  input  logic        m_ready_i,
  output logic        overflow_o
);

  localparam int addr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int cnt_w  = $clog2(fifo_depth + 1);

  frame_beat_t       mem [fifo_depth];
  logic [addr_w-1:0] wr_ptr_q, rd_ptr_q;
  logic [cnt_w-1:0]  count_q;
  logic              full, push, pop;

  // pointer wrap for any depth
  function automatic logic [addr_w-1:0] ptr_inc(input logic [addr_w-1:0] ptr);
    return (ptr == addr_w'(fifo_depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full      = (count_q == cnt_w'(fifo_depth));
  assign push      = beat_valid_i & ~full;
  assign pop       = m_valid_o & m_ready_i;
  assign m_valid_o = (count_q != '0);
  assign m_beat_o  = mem[rd_ptr_q];  // head held until taken

  always_ff @(posedge clk_245_76MHz) begin
    if (push) mem[wr_ptr_q] <= beat_i;
  end

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // none or both
      endcase
      if (beat_valid_i && full) overflow_o <= 1'b1;  // sticky until reset
    end
  end

  a_count_bound : assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    count_q <= cnt_w'(fifo_depth))
    else $error("fifo count past depth");

endmodule

// File: hdl/capture/frame_assembler.sv
// frame word builder
// keeps the global and sample counters, routes four sources onto the
// two halves of each data word and forms the FRST / LAST marker words
module frame_assembler
  import radar_cfg_pkg::*;
  import radar_types_pkg::*;
(
  input  logic        clk_245_76MHz,
  input  logic        cpu_reset,
  input  slot_e       slot_i,
  input  route_e      route_hi_i,
  input  route_e      route_lo_i,
  input  iq_sample_t  sample_i,
  output frame_beat_t beat_o,
  output logic        beat_valid_o
);

  logic [iq_w_c-1:0] glbl_cnt_q;    // free running timestamp
  logic [iq_w_c-1:0] sample_cnt_q;  // beats written, all frames
  frame_word_u       word_d;

  // one source mux, used for each half
  function automatic logic [iq_w_c-1:0] route_mux(
    input route_e            sel,
    input iq_sample_t        smp,
    input logic [iq_w_c-1:0] scnt,
    input logic [iq_w_c-1:0] gcnt
  );
    case (sel)
      route_adc:        return smp.adc_iq;
      route_dac:        return smp.dac_iq;
      route_sample_cnt: return scnt;
      default:          return gcnt;
    endcase
  endfunction

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      glbl_cnt_q   <= '0;
      sample_cnt_q <= '0;
    end else begin
      glbl_cnt_q <= glbl_cnt_q + 1'b1;
      if (slot_i != slot_none) sample_cnt_q <= sample_cnt_q + 1'b1;
    end
  end

  // markers use the marker view, everything else the data view
  always_comb begin
    word_d = '0;
    case (slot_i)
      slot_header: begin
        word_d.marker.timestamp = glbl_cnt_q;
        word_d.marker.command   = cmd_first_c;
      end
      slot_trailer: begin
        word_d.marker.timestamp = glbl_cnt_q;
        word_d.marker.command   = cmd_last_c;
      end
      default: begin
        word_d.data.upper = route_mux(route_hi_i, sample_i, sample_cnt_q, glbl_cnt_q);
        word_d.data.lower = route_mux(route_lo_i, sample_i, sample_cnt_q, glbl_cnt_q);
      end
    endcase
  end

  always_ff @(posedge clk_245_76MHz) begin
    beat_o.word <= word_d;
    beat_o.last <= (slot_i == slot_trailer);  // trailer closes the frame
  end

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) beat_valid_o <= 1'b0;
    else beat_valid_o <= (slot_i != slot_none);
  end

  // routes from capture_ctrl must hold while data words are built
  a_route_stable : assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    (slot_i == slot_data) |-> $stable({route_hi_i, route_lo_i}))
    else $error("route select changed inside a frame");

endmodule

// File: hdl/capture/capture_ctrl.sv
// capture window sequencer
// syncs adc enable, applies the source dependent start and end delays,
// then marks each valid sample as header, data, padding or trailer so
// that every frame closes on a 64 word boundary
module capture_ctrl
  import radar_cfg_pkg::*;
  import radar_types_pkg::*;
(
  input  logic          clk_245_76MHz,
  input  logic          cpu_reset,
  input  iq_sample_t    sample_i,
  input  capture_ctrl_t ctrl_i,
  output slot_e         slot_o,
  output route_e        route_hi_o,
  output route_e        route_lo_o,
  output iq_sample_t    sample_o
);

  typedef enum logic [2:0] {st_idle, st_start, st_open, st_end, st_pad} state_e;

  state_e               state_q;
  logic                 en_r, en_rr;     // enable sync pair
  logic                 en_rise, en_fall;
  logic [1:0]           src_sel_q;
  logic                 wfrm_sel;
  logic [dly_w_c-1:0]   dly_cnt_q;
  logic [align_w_c-1:0] word_cnt_q;      // beats so far, mod 64
  logic                 frame_open_q;

  assign en_rise  = en_r & ~en_rr;
  assign en_fall  = ~en_r & en_rr;
  assign wfrm_sel = &src_sel_q;          // both bits set selects waveform

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      en_r  <= 1'b0;
      en_rr <= 1'b0;
    end else begin
      en_r  <= ctrl_i.adc_enable;
      en_rr <= en_r;
    end
  end

  // selects only follow the control word between chirps
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      route_hi_o <= route_adc;
      route_lo_o <= route_dac;
      src_sel_q  <= 2'b00;
    end else if (!ctrl_i.chirp_enable) begin
      route_hi_o <= route_e'(ctrl_i.ctrl_word[5:4]);
      route_lo_o <= route_e'(ctrl_i.ctrl_word[1:0]);
      src_sel_q  <= ctrl_i.ctrl_word[9:8];
    end
  end

  always_ff @(posedge clk_245_76MHz) begin
    sample_o <= sample_i;  // keeps sample aligned with its slot
  end

  ////////////////////////////////////////////////////////////////////////////
  // window FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      state_q    <= st_idle;
      slot_o     <= slot_none;
      dly_cnt_q  <= '0;
      word_cnt_q <= '0;
    end else begin
      slot_o <= slot_none;
      case (state_q)
        st_idle: begin
          if (en_rise) begin
            dly_cnt_q <= wfrm_sel ? dly_w_c'(wfrm_start_dly_c) : dly_w_c'(chirp_start_dly_c);
            state_q   <= st_start;
          end
        end
        st_start: begin
          if (en_fall) begin
            state_q <= st_idle;  // window dropped before it opened
          end else if (sample_i.valid) begin
            if (dly_cnt_q != '0) begin
              dly_cnt_q <= dly_cnt_q - 1'b1;
            end else begin
              slot_o     <= slot_header;
              word_cnt_q <= align_w_c'(1);
              state_q    <= st_open;
            end
          end
        end
        st_open: begin
          if (sample_i.valid) begin
            slot_o     <= slot_data;
            word_cnt_q <= word_cnt_q + 1'b1;
          end
          if (en_fall) begin
            dly_cnt_q <= wfrm_sel ? dly_w_c'(wfrm_end_dly_c) : dly_w_c'(chirp_end_dly_c);
            state_q   <= st_end;
          end
        end
        st_end: begin  // dds tail still in flight
          if (sample_i.valid) begin
            slot_o     <= slot_data;
            word_cnt_q <= word_cnt_q + 1'b1;
            dly_cnt_q  <= dly_cnt_q - 1'b1;
            if (dly_cnt_q == dly_w_c'(1)) state_q <= st_pad;
          end
        end
        st_pad: begin
          if (sample_i.valid) begin
            if (&word_cnt_q) begin  // trailer makes the count a multiple of 64
              slot_o  <= slot_trailer;
              state_q <= st_idle;
            end else begin
              slot_o     <= slot_data;
              word_cnt_q <= word_cnt_q + 1'b1;
            end
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // frame open from header out to trailer out
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) frame_open_q <= 1'b0;
    else if (slot_o == slot_header) frame_open_q <= 1'b1;
    else if (slot_o == slot_trailer) frame_open_q <= 1'b0;
  end

  a_no_nested_header : assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    (slot_o == slot_header) |-> !frame_open_q)
    else $error("header issued inside an open frame");

endmodule

// File: common/radar_types_pkg.sv
// radar capture data types
// sample and control bundles, frame slot codes and the 64-bit frame
// word, which is read as data or as a marker depending on its slot
package radar_types_pkg;

  import radar_cfg_pkg::*;

  // one sample cycle from the converters
  typedef struct packed {
    logic [iq_w_c-1:0] adc_iq;  // {i, q}
    logic [iq_w_c-1:0] dac_iq;  // {i, q}
    logic              valid;
  } iq_sample_t;

  // control word bits
  //   1:0 route_lo, 5:4 route_hi, 9:8 source select (both set = waveform)
  typedef struct packed {
    logic [1:0]  spare;
    logic        chirp_enable;
    logic        adc_enable;
    logic [31:0] ctrl_word;
  } capture_ctrl_t;

  // what a beat carries in the frame
  typedef enum logic [1:0] {
    slot_none    = 2'd0,
    slot_header  = 2'd1,
    slot_data    = 2'd2,
    slot_trailer = 2'd3
  } slot_e;

  typedef struct packed {
    logic [iq_w_c-1:0] upper;
    logic [iq_w_c-1:0] lower;
  } data_word_t;

  typedef struct packed {
    logic [31:0] timestamp;  // global counter at the marker
    logic [31:0] command;    // FRST or LAST
  } marker_word_t;

  // same 64 bits, two readings
  typedef union packed {
    data_word_t   data;
    marker_word_t marker;
  } frame_word_u;

  typedef struct packed {
    frame_word_u word;
    logic        last;  // set on the trailer only
  } frame_beat_t;

endpackage

// File: common/radar_cfg_pkg.sv
// radar capture configuration
// frame alignment, marker command words, enable delays and the
// route select codes shared by the capture blocks
package radar_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sample and frame geometry
  ////////////////////////////////////////////////////////////////////////////

  parameter int unsigned iq_w_c        = 32;  // one packed I/Q pair
  parameter int unsigned frame_align_c = 64;  // frames are whole multiples of this
  parameter int unsigned align_w_c     = $clog2(frame_align_c);

  ////////////////////////////////////////////////////////////////////////////
  // marker commands
  ////////////////////////////////////////////////////////////////////////////

  parameter logic [31:0] cmd_first_c = 32'h4652_5354;  // ascii FRST
  parameter logic [31:0] cmd_last_c  = 32'h4c41_5354;  // ascii LAST

  ////////////////////////////////////////////////////////////////////////////
  // enable delays, counted in sample-valid cycles
  ////////////////////////////////////////////////////////////////////////////

  parameter int unsigned dly_w_c = 5;  // wide enough for the longest delay

  // chirp dds path is short, waveform playback needs longer to fill
  parameter int unsigned chirp_start_dly_c = 4;
  parameter int unsigned wfrm_start_dly_c  = 19;

  // end delays must stay at 1 or more
  parameter int unsigned chirp_end_dly_c = 4;
  parameter int unsigned wfrm_end_dly_c  = 2;

  // sources for each half of a data word
  typedef enum logic [1:0] {
    route_adc        = 2'd0,  // adc I/Q pair
    route_dac        = 2'd1,  // dac I/Q pair
    route_sample_cnt = 2'd2,  // captured sample counter
    route_glbl_cnt   = 2'd3   // free running counter
  } route_e;

endpackage
